// ==== verilog/wb_pkg.sv ====
// Shared widths, memory operation codes and instruction field constants for the writeback stage
`default_nettype none

package wb_pkg;

	// Datapath geometry
	localparam int VECTOR_LANES = 4;
	localparam int LANE_BITS = 32;
	localparam int VECTOR_BITS = 128;
	localparam int INSTR_BITS = 32;
	localparam int LANE_SELECT_WIDTH = 2;

	// Register index is strand in the upper bits, register number below
	localparam int REG_IDX_WIDTH = 7;
	localparam int STRAND_INDEX_WIDTH = 2;
	localparam int REG_NUM_WIDTH = REG_IDX_WIDTH - STRAND_INDEX_WIDTH;
	localparam logic [REG_NUM_WIDTH-1:0] PC_REG = 5'd31;

	localparam logic [INSTR_BITS-1:0] NOP = '0;

	// Format C memory instruction fields
	localparam logic [1:0] FMT_C = 2'b10;
	localparam int LOAD_BIT = 29;
	localparam int OP_MSB = 28;
	localparam int OP_LSB = 25;

	// Load and store widths
	typedef enum logic [3:0] {
		MEM_B           = 4'd0,
		MEM_BX          = 4'd1,
		MEM_S           = 4'd2,
		MEM_SX          = 4'd3,
		MEM_L           = 4'd4,
		MEM_SYNC        = 4'd5,
		MEM_CONTROL_REG = 4'd6,
		MEM_BLOCK       = 4'd7,
		MEM_BLOCK_M     = 4'd8,
		MEM_BLOCK_IM    = 4'd9,
		MEM_STRIDED     = 4'd10,
		MEM_STRIDED_M   = 4'd11,
		MEM_STRIDED_IM  = 4'd12,
		MEM_SCGATH      = 4'd13,
		MEM_SCGATH_M    = 4'd14,
		MEM_SCGATH_IM   = 4'd15
	} mem_op_t;

endpackage

`default_nettype wire

// ==== verilog/wb_stage_if.sv ====
// Latched and decoded memory-access results shared by the writeback stage submodules
`timescale 1ns/1ns
`default_nettype none

interface wb_stage_if;
	import wb_pkg::*;

	// Latched memory-access results
	logic [LANE_BITS-1:0] pc;
	logic [REG_IDX_WIDTH-1:0] writeback_reg;
	logic enable_scalar_writeback;
	logic enable_vector_writeback;
	logic [VECTOR_LANES-1:0] mask;
	logic [VECTOR_BITS-1:0] result;
	logic [LANE_SELECT_WIDTH-1:0] reg_lane_select;
	logic [LANE_SELECT_WIDTH-1:0] cache_lane_select;
	logic [STRAND_INDEX_WIDTH-1:0] strand;
	logic was_load;
	logic was_io;
	logic [LANE_BITS-1:0] io_response;
	logic alignment_fault;

	// Decoded once from the instruction word
	logic is_load;
	logic is_sync_store;
	logic is_control_transfer;
	logic is_nop;
	mem_op_t op_type;

	modport latch (output pc, writeback_reg, enable_scalar_writeback, enable_vector_writeback,
		mask, result, reg_lane_select, cache_lane_select, strand, was_load, was_io,
		io_response, alignment_fault, is_load, is_sync_store, is_control_transfer, is_nop,
		op_type);

	modport aligner (input result, cache_lane_select, op_type);

	modport detector (input pc, writeback_reg, enable_scalar_writeback, strand, was_load,
		was_io, alignment_fault, is_load);

	modport writer (input writeback_reg, enable_scalar_writeback, enable_vector_writeback,
		mask, result, reg_lane_select, was_io, io_response, is_load, is_sync_store,
		is_control_transfer, is_nop, op_type);
endinterface

`default_nettype wire

// ==== verilog/ma_result_latch.sv ====
// Input pipeline register that holds the memory-access outputs and decodes the instruction
`timescale 1ns/1ns
`default_nettype none

module ma_result_latch (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [wb_pkg::INSTR_BITS-1:0]          ma_instruction,
	input  logic [wb_pkg::LANE_BITS-1:0]           ma_pc,
	input  logic [wb_pkg::REG_IDX_WIDTH-1:0]       ma_writeback_reg,
	input  logic                                   ma_enable_scalar_writeback,
	input  logic                                   ma_enable_vector_writeback,
	input  logic [wb_pkg::VECTOR_LANES-1:0]        ma_mask,
	input  logic                                   ma_was_load,
	input  logic                                   ma_alignment_fault,
	input  logic [wb_pkg::VECTOR_BITS-1:0]         ma_result,
	input  logic [wb_pkg::LANE_SELECT_WIDTH-1:0]   ma_reg_lane_select,
	input  logic [wb_pkg::LANE_SELECT_WIDTH-1:0]   ma_cache_lane_select,
	input  logic [wb_pkg::STRAND_INDEX_WIDTH-1:0]  ma_strand,
	input  logic                                   ma_was_io,
	input  logic [wb_pkg::LANE_BITS-1:0]           ma_io_response,
	wb_stage_if.latch                              stage
);
	import wb_pkg::*;

	logic is_fmt_c;
	mem_op_t op_decoded;

	// Decode on the way in so the flags leave the register together
	assign is_fmt_c = ma_instruction[INSTR_BITS-1 -: 2] == FMT_C;
	assign op_decoded = mem_op_t'(ma_instruction[OP_MSB:OP_LSB]);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Idle as a NOP with nothing enabled
			stage.pc <= '0;
			stage.writeback_reg <= '0;
			stage.enable_scalar_writeback <= 1'b0;
			stage.enable_vector_writeback <= 1'b0;
			stage.mask <= '0;
			stage.result <= '0;
			stage.reg_lane_select <= '0;
			stage.cache_lane_select <= '0;
			stage.strand <= '0;
			stage.was_load <= 1'b0;
			stage.was_io <= 1'b0;
			stage.io_response <= '0;
			stage.alignment_fault <= 1'b0;
			stage.is_load <= 1'b0;
			stage.is_sync_store <= 1'b0;
			stage.is_control_transfer <= 1'b0;
			stage.is_nop <= 1'b1;
			stage.op_type <= MEM_B;
		end
		else
		begin
			stage.pc <= ma_pc;
			stage.writeback_reg <= ma_writeback_reg;
			stage.enable_scalar_writeback <= ma_enable_scalar_writeback;
			stage.enable_vector_writeback <= ma_enable_vector_writeback;
			stage.mask <= ma_mask;
			stage.result <= ma_result;
			stage.reg_lane_select <= ma_reg_lane_select;
			stage.cache_lane_select <= ma_cache_lane_select;
			stage.strand <= ma_strand;
			stage.was_load <= ma_was_load;
			stage.was_io <= ma_was_io;
			stage.io_response <= ma_io_response;
			stage.alignment_fault <= ma_alignment_fault;
			stage.is_load <= is_fmt_c && ma_instruction[LOAD_BIT];
			// Store form of the synchronized op
			stage.is_sync_store <= is_fmt_c && !ma_instruction[LOAD_BIT]
				&& op_decoded == MEM_SYNC;
			stage.is_control_transfer <= is_fmt_c && op_decoded == MEM_CONTROL_REG;
			stage.is_nop <= ma_instruction == NOP;
			stage.op_type <= op_decoded;
		end
	end
endmodule

`default_nettype wire

// ==== verilog/load_aligner.sv ====
// Selects and aligns load data from the data cache line and byte-swaps the whole line
`timescale 1ns/1ns
`default_nettype none

module load_aligner (
	wb_stage_if.aligner                       stage,
	input  logic [wb_pkg::VECTOR_BITS-1:0]    dcache_data,
	output logic [wb_pkg::LANE_BITS-1:0]      aligned_value,
	output logic [wb_pkg::VECTOR_BITS-1:0]    swapped_line
);
	import wb_pkg::*;

	logic [LANE_BITS-1:0] lane_value;
	logic [7:0] byte_value;
	logic [15:0] half_value;
	logic [1:0] byte_offset;

	// Reverse the four bytes of one word
	function automatic logic [LANE_BITS-1:0] swap_word(input logic [LANE_BITS-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Result still carries the effective address
	assign byte_offset = stage.result[1:0];

	// Lane 0 sits in the top word of the line
	assign lane_value = dcache_data[VECTOR_BITS - 1 - LANE_BITS * stage.cache_lane_select
		-: LANE_BITS];

	// Offset 0 is the most significant byte
	assign byte_value = lane_value[LANE_BITS - 1 - 8 * byte_offset -: 8];

	// Halfword bytes come out in swapped order
	assign half_value = {lane_value[LANE_BITS - 9 - 16 * byte_offset[1] -: 8],
		lane_value[LANE_BITS - 1 - 16 * byte_offset[1] -: 8]};

	// Width and sign extension
	always_comb
	begin
		case (stage.op_type)
			MEM_B:   aligned_value = {{(LANE_BITS - 8){1'b0}}, byte_value};
			MEM_BX:  aligned_value = {{(LANE_BITS - 8){byte_value[7]}}, byte_value};
			MEM_S:   aligned_value = {{(LANE_BITS - 16){1'b0}}, half_value};
			MEM_SX:  aligned_value = {{(LANE_BITS - 16){half_value[15]}}, half_value};
			// Word and everything else
			default: aligned_value = swap_word(lane_value);
		endcase
	end

	// Block loads take every word byte-reversed
	always_comb
	begin
		for (int i = 0; i < VECTOR_LANES; i++)
			swapped_line[i * LANE_BITS +: LANE_BITS] = swap_word(dcache_data[i * LANE_BITS
				+: LANE_BITS]);
	end
endmodule

`default_nettype wire

// ==== verilog/rollback_detector.sv ====
// Prioritized rollback, suspend, retry and alignment fault decisions for the writeback stage
`timescale 1ns/1ns
`default_nettype none

module rollback_detector (
	wb_stage_if.detector                             stage,
	input  logic                                     dcache_hit,
	input  logic                                     dcache_load_collision,
	input  logic                                     stbuf_rollback,
	input  logic [wb_pkg::LANE_BITS-1:0]             cr_exception_handler_address,
	input  logic [wb_pkg::LANE_BITS-1:0]             aligned_value,
	output logic                                     rollback_request,
	output logic [wb_pkg::LANE_BITS-1:0]             rollback_pc,
	output logic                                     suspend_request,
	output logic                                     retry,
	output logic                                     latch_fault,
	output logic [wb_pkg::LANE_BITS-1:0]             fault_pc,
	output logic [wb_pkg::STRAND_INDEX_WIDTH-1:0]    fault_strand
);
	import wb_pkg::*;

	logic cache_miss;
	logic pc_load;

	// Collision takes precedence over a miss
	assign cache_miss = !dcache_hit && stage.was_load && !dcache_load_collision;
	assign pc_load = stage.enable_scalar_writeback && stage.is_load
		&& stage.writeback_reg[REG_NUM_WIDTH-1:0] == PC_REG;

	// First match wins
	always_comb
	begin
		rollback_request = 1'b1;
		rollback_pc = stage.pc - 32'd4;
		if (stage.alignment_fault)
			rollback_pc = cr_exception_handler_address;
		else if (stage.was_io)
		begin
			// Device access ignores the cache
			rollback_request = 1'b0;
			rollback_pc = '0;
		end
		else if (dcache_load_collision || cache_miss || stbuf_rollback)
			rollback_pc = stage.pc - 32'd4;
		// Only valid once a miss has been ruled out
		else if (pc_load)
			rollback_pc = aligned_value;
		else
		begin
			rollback_request = 1'b0;
			rollback_pc = '0;
		end
	end

	// Reported regardless of priority
	assign suspend_request = cache_miss || stbuf_rollback;
	assign retry = dcache_load_collision;

	// Fault details go to the control registers
	assign latch_fault = stage.alignment_fault;
	assign fault_pc = stage.pc;
	assign fault_strand = stage.strand;
endmodule

`default_nettype wire

// ==== verilog/writeback_register.sv ====
// Chooses and registers the register-file writeback value, mask and enables, and flags retirement
`timescale 1ns/1ns
`default_nettype none

module writeback_register (
	input  logic                                 clk,
	input  logic                                 reset,
	wb_stage_if.writer                           stage,
	input  logic [wb_pkg::LANE_BITS-1:0]         aligned_value,
	input  logic [wb_pkg::VECTOR_BITS-1:0]       swapped_line,
	input  logic [wb_pkg::VECTOR_BITS-1:0]       dcache_data,
	input  logic                                 rollback_request,
	output logic                                 wb_enable_scalar,
	output logic                                 wb_enable_vector,
	output logic [wb_pkg::REG_IDX_WIDTH-1:0]     wb_writeback_reg,
	output logic [wb_pkg::VECTOR_BITS-1:0]       wb_writeback_value,
	output logic [wb_pkg::VECTOR_LANES-1:0]      wb_writeback_mask,
	output logic                                 instruction_retire
);
	import wb_pkg::*;

	logic [VECTOR_BITS-1:0] value_nxt;
	logic [VECTOR_LANES-1:0] mask_nxt;
	logic [VECTOR_LANES-1:0] lane_bit;
	logic is_block;

	assign lane_bit = VECTOR_LANES'(1) << stage.reg_lane_select;
	assign is_block = stage.op_type inside {MEM_BLOCK, MEM_BLOCK_M, MEM_BLOCK_IM};

	// Writeback source and mask
	always_comb
	begin
		value_nxt = stage.result;
		mask_nxt = stage.mask;
		if (stage.is_sync_store)
		begin
			// Success flag comes back in the line
			value_nxt = dcache_data;
			mask_nxt = '1;
		end
		else if (stage.is_load && !stage.is_control_transfer)
		begin
			if (stage.was_io)
			begin
				value_nxt = {VECTOR_LANES{stage.io_response}};
				mask_nxt = '1;
			end
			else if (!stage.op_type[3] && !is_block)
			begin
				// Scalar load to every lane
				value_nxt = {VECTOR_LANES{aligned_value}};
				mask_nxt = '1;
			end
			else if (is_block)
				value_nxt = swapped_line;
			else
			begin
				// Strided or gather fills one lane per access
				value_nxt = {VECTOR_LANES{aligned_value}};
				mask_nxt = lane_bit & stage.mask;
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_enable_scalar <= 1'b0;
			wb_enable_vector <= 1'b0;
			wb_writeback_reg <= '0;
			wb_writeback_value <= '0;
			wb_writeback_mask <= '0;
		end
		else
		begin
			wb_enable_scalar <= stage.enable_scalar_writeback && !rollback_request;
			wb_enable_vector <= stage.enable_vector_writeback && !rollback_request;
			wb_writeback_reg <= stage.writeback_reg;
			wb_writeback_value <= value_nxt;
			wb_writeback_mask <= mask_nxt;
		end
	end

	// Retire event in the same cycle as the rollback decision
	assign instruction_retire = !rollback_request && !stage.is_nop;
endmodule

`default_nettype wire

// ==== verilog/wb_subsystem.sv ====
// Top level of the writeback stage that ties the input latch, aligner, rollback logic and writer
`timescale 1ns/1ns
`default_nettype none

module wb_subsystem (
	input  logic                                   clk,
	input  logic                                   reset,
	// Memory access stage
	input  logic [wb_pkg::INSTR_BITS-1:0]          ma_instruction,
	input  logic [wb_pkg::LANE_BITS-1:0]           ma_pc,
	input  logic [wb_pkg::REG_IDX_WIDTH-1:0]       ma_writeback_reg,
	input  logic                                   ma_enable_scalar_writeback,
	input  logic                                   ma_enable_vector_writeback,
	input  logic [wb_pkg::VECTOR_LANES-1:0]        ma_mask,
	input  logic                                   ma_was_load,
	input  logic                                   ma_alignment_fault,
	input  logic [wb_pkg::VECTOR_BITS-1:0]         ma_result,
	input  logic [wb_pkg::LANE_SELECT_WIDTH-1:0]   ma_reg_lane_select,
	input  logic [wb_pkg::LANE_SELECT_WIDTH-1:0]   ma_cache_lane_select,
	input  logic [wb_pkg::STRAND_INDEX_WIDTH-1:0]  ma_strand,
	input  logic                                   ma_was_io,
	input  logic [wb_pkg::LANE_BITS-1:0]           ma_io_response,
	// Data cache, one cycle behind
	input  logic                                   dcache_hit,
	input  logic [wb_pkg::VECTOR_BITS-1:0]         dcache_data,
	input  logic                                   dcache_load_collision,
	input  logic                                   stbuf_rollback,
	input  logic [wb_pkg::LANE_BITS-1:0]           cr_exception_handler_address,
	// Register file
	output logic                                   wb_enable_scalar,
	output logic                                   wb_enable_vector,
	output logic [wb_pkg::REG_IDX_WIDTH-1:0]       wb_writeback_reg,
	output logic [wb_pkg::VECTOR_BITS-1:0]         wb_writeback_value,
	output logic [wb_pkg::VECTOR_LANES-1:0]        wb_writeback_mask,
	// Rollback controller and control registers
	output logic                                   rollback_request,
	output logic [wb_pkg::LANE_BITS-1:0]           rollback_pc,
	output logic                                   suspend_request,
	output logic                                   retry,
	output logic                                   latch_fault,
	output logic [wb_pkg::LANE_BITS-1:0]           fault_pc,
	output logic [wb_pkg::STRAND_INDEX_WIDTH-1:0]  fault_strand,
	output logic                                   instruction_retire
);
	import wb_pkg::*;

	logic [LANE_BITS-1:0] aligned_value;
	logic [VECTOR_BITS-1:0] swapped_line;

	wb_stage_if stage ();

	ma_result_latch i_latch (
		.clk(clk), .reset(reset), .ma_instruction(ma_instruction), .ma_pc(ma_pc),
		.ma_writeback_reg(ma_writeback_reg),
		.ma_enable_scalar_writeback(ma_enable_scalar_writeback),
		.ma_enable_vector_writeback(ma_enable_vector_writeback), .ma_mask(ma_mask),
		.ma_was_load(ma_was_load), .ma_alignment_fault(ma_alignment_fault),
		.ma_result(ma_result), .ma_reg_lane_select(ma_reg_lane_select),
		.ma_cache_lane_select(ma_cache_lane_select), .ma_strand(ma_strand),
		.ma_was_io(ma_was_io), .ma_io_response(ma_io_response), .stage(stage.latch));

	load_aligner i_aligner (
		.stage(stage.aligner), .dcache_data(dcache_data), .aligned_value(aligned_value),
		.swapped_line(swapped_line));

	rollback_detector i_detector (
		.stage(stage.detector), .dcache_hit(dcache_hit),
		.dcache_load_collision(dcache_load_collision), .stbuf_rollback(stbuf_rollback),
		.cr_exception_handler_address(cr_exception_handler_address),
		.aligned_value(aligned_value), .rollback_request(rollback_request),
		.rollback_pc(rollback_pc), .suspend_request(suspend_request), .retry(retry),
		.latch_fault(latch_fault), .fault_pc(fault_pc), .fault_strand(fault_strand));

	writeback_register i_writer (
		.clk(clk), .reset(reset), .stage(stage.writer), .aligned_value(aligned_value),
		.swapped_line(swapped_line), .dcache_data(dcache_data),
		.rollback_request(rollback_request), .wb_enable_scalar(wb_enable_scalar),
		.wb_enable_vector(wb_enable_vector), .wb_writeback_reg(wb_writeback_reg),
		.wb_writeback_value(wb_writeback_value), .wb_writeback_mask(wb_writeback_mask),
		.instruction_retire(instruction_retire));
endmodule

`default_nettype wire

// ==== verification/wb_subsystem_asserts.sv ====
// Concurrent protocol checks on the writeback stage, bound to its top level
`timescale 1ns/1ns
`default_nettype none

module wb_subsystem_asserts (
	input logic        clk,
	input logic        reset,
	input logic        retry,
	input logic        rollback_request,
	input logic [31:0] rollback_pc,
	input logic        latch_fault,
	input logic [31:0] cr_exception_handler_address,
	input logic        wb_enable_scalar,
	input logic        wb_enable_vector
);
	// Failed assertions so far
	int fail_count = 0;

	// Collision always refetches
	a_retry_rollback: assert property (@(posedge clk) disable iff (reset)
		retry |-> rollback_request)
		else
		begin
			fail_count++;
			$error("retry without rollback");
		end

	// Rolled back work never reaches the register file
	a_no_write_after_rollback: assert property (@(posedge clk) disable iff (reset)
		rollback_request |=> !wb_enable_scalar && !wb_enable_vector)
		else
		begin
			fail_count++;
			$error("writeback enable after rollback");
		end

	a_fault_handler: assert property (@(posedge clk) disable iff (reset)
		latch_fault |-> rollback_request && rollback_pc == cr_exception_handler_address)
		else
		begin
			fail_count++;
			$error("fault without rollback to handler");
		end
endmodule

bind wb_subsystem wb_subsystem_asserts i_asserts (.*);

`default_nettype wire

// ==== verification/wb_subsystem_tb.sv ====
// Table-driven testbench for the writeback stage, with LFSR cache lines and a watchdog
`timescale 1ns/1ns
`default_nettype none

module wb_subsystem_tb;
	localparam int NUM_RANDOM = 24;
	localparam int NUM_TOTAL = 19 + NUM_RANDOM;
	localparam logic [127:0] LINE = 128'h80F17F02_A1B2C3D4_11223344_FEDCBA98;
	localparam logic [31:0] HANDLER = 32'h0000_F000;
	localparam logic [31:0] IO_WORD = 32'h10A0_5EED;

	// Flag fields maf {was_load, was_io, fault} and cf {hit, collision, stbuf}
	// expf {rollback, suspend, retry, retire, enable_scalar, enable_vector}
	typedef struct {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [6:0] wreg;
		logic [1:0] en;
		logic [3:0] mask;
		logic [1:0] clane;
		logic [1:0] rlane;
		logic [1:0] off;
		logic [2:0] maf;
		logic [2:0] cf;
		logic [127:0] line;
		logic [5:0] expf;
		logic [31:0] exp_pc;
		logic [127:0] exp_val;
		logic [3:0] exp_mask;
	} entry_t;

	logic clk, reset;
	logic [31:0] ma_instruction, ma_pc, ma_io_response, cr_exception_handler_address;
	logic [6:0] ma_writeback_reg;
	logic ma_enable_scalar_writeback, ma_enable_vector_writeback;
	logic [3:0] ma_mask;
	logic ma_was_load, ma_alignment_fault, ma_was_io;
	logic [127:0] ma_result, dcache_data;
	logic [1:0] ma_reg_lane_select, ma_cache_lane_select, ma_strand;
	logic dcache_hit, dcache_load_collision, stbuf_rollback;
	logic wb_enable_scalar, wb_enable_vector, rollback_request, suspend_request, retry;
	logic [6:0] wb_writeback_reg;
	logic [127:0] wb_writeback_value;
	logic [3:0] wb_writeback_mask;
	logic [31:0] rollback_pc, fault_pc;
	logic latch_fault, instruction_retire;
	logic [1:0] fault_strand;

	entry_t tbl[$];
	int errors = 0;
	int checks = 0;
	logic [15:0] lfsr = 16'd16010;

	wb_subsystem i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] mem_instr(input logic load, input logic [3:0] op);
		return {2'b10, load, op, 25'd0};
	endfunction

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [127:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[126:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Byte k of a lane is the k-th from the top
	// Halfwords come out byte-swapped
	function automatic logic [31:0] model_load(input logic [127:0] line, input logic [1:0] lane,
		input logic [1:0] off, input logic [3:0] op);
		logic [31:0] word;
		logic [7:0] b [4];
		logic [1:0] h;
		word = 32'(line >> (32 * (3 - lane)));
		for (int k = 0; k < 4; k++)
			b[k] = 8'(word >> (8 * (3 - k)));
		h = {off[1], 1'b0};
		case (op)
			4'd0: return {24'd0, b[off]};
			4'd1: return {{24{b[off][7]}}, b[off]};
			4'd2: return {16'd0, b[h + 1], b[h]};
			4'd3: return {{16{b[h + 1][7]}}, b[h + 1], b[h]};
			default: return {b[3], b[2], b[1], b[0]};
		endcase
	endfunction

	task automatic add(input logic [31:0] instr, pc, input logic [6:0] wreg,
		input logic [1:0] en, input logic [3:0] mask, input logic [1:0] clane, rlane, off,
		input logic [2:0] maf, cf, input logic [5:0] expf, input logic [31:0] exp_pc,
		input logic [127:0] exp_val, input logic [3:0] exp_mask);
		tbl.push_back('{instr, pc, wreg, en, mask, clane, rlane, off, maf, cf, LINE, expf,
			exp_pc, exp_val, exp_mask});
	endtask

	task automatic check(input string name, input logic [127:0] got, exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic drive_ma(input entry_t e, input logic idle);
		ma_instruction = idle ? 32'd0 : e.instr;
		ma_pc = e.pc;
		ma_writeback_reg = e.wreg;
		ma_strand = e.wreg[6:5];
		{ma_enable_scalar_writeback, ma_enable_vector_writeback} = idle ? 2'b00 : e.en;
		ma_mask = e.mask;
		ma_cache_lane_select = e.clane;
		ma_reg_lane_select = e.rlane;
		ma_result = {4{32'hC0DE0000 | 32'(e.off)}};
		{ma_was_load, ma_was_io, ma_alignment_fault} = idle ? 3'b000 : e.maf;
		ma_io_response = IO_WORD;
	endtask

	task automatic drive_cache(input entry_t e, input logic idle);
		{dcache_hit, dcache_load_collision, stbuf_rollback} = idle ? 3'b000 : e.cf;
		dcache_data = e.line;
	endtask

	task automatic check_comb(input entry_t e);
		check("rollback_request", 128'(rollback_request), 128'(e.expf[5]));
		if (e.expf[5])
			check("rollback_pc", 128'(rollback_pc), 128'(e.exp_pc));
		check("suspend_request", 128'(suspend_request), 128'(e.expf[4]));
		check("retry", 128'(retry), 128'(e.expf[3]));
		check("instruction_retire", 128'(instruction_retire), 128'(e.expf[2]));
		check("latch_fault", 128'(latch_fault), 128'(e.maf[0]));
		check("fault_pc", 128'(fault_pc), 128'(e.pc));
		check("fault_strand", 128'(fault_strand), 128'(e.wreg[6:5]));
	endtask

	task automatic check_wb(input entry_t e);
		check("wb_enable_scalar", 128'(wb_enable_scalar), 128'(e.expf[1]));
		check("wb_enable_vector", 128'(wb_enable_vector), 128'(e.expf[0]));
		check("wb_writeback_reg", 128'(wb_writeback_reg), 128'(e.wreg));
		check("wb_writeback_value", wb_writeback_value, e.exp_val);
		check("wb_writeback_mask", 128'(wb_writeback_mask), 128'(e.exp_mask));
	endtask

	// Watchdog sized from the number of entries
	initial
	begin
		repeat (NUM_TOTAL * 20 + 50) @(posedge clk);
		$display("Timeout: the run did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		entry_t idle_e;
		entry_t e;
		logic [127:0] r;
		logic [127:0] line_r;
		logic [3:0] op;
		logic [31:0] val;
		idle_e = '{32'd0, 32'd0, 7'd0, 2'd0, 4'd0, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 128'd0,
			6'd0, 32'd0, 128'd0, 4'd0};
		reset = 1'b1;
		cr_exception_handler_address = HANDLER;
		drive_ma(idle_e, 1'b1);
		drive_cache(idle_e, 1'b1);

		// Scalar loads of each width and offset
		add(mem_instr(1, 0), 32'h100, 7'h23, 2'b10, 4'hF, 0, 0, 0, 3'b100, 3'b100, 6'b000110,
			0, {4{32'h00000080}}, 4'hF);
		add(mem_instr(1, 1), 32'h104, 7'h23, 2'b10, 4'hF, 0, 0, 0, 3'b100, 3'b100, 6'b000110,
			0, {4{32'hFFFFFF80}}, 4'hF);
		add(mem_instr(1, 1), 32'h108, 7'h23, 2'b10, 4'hF, 0, 0, 2, 3'b100, 3'b100, 6'b000110,
			0, {4{32'h0000007F}}, 4'hF);
		add(mem_instr(1, 2), 32'h10C, 7'h23, 2'b10, 4'hF, 1, 0, 0, 3'b100, 3'b100, 6'b000110,
			0, {4{32'h0000B2A1}}, 4'hF);
		add(mem_instr(1, 3), 32'h110, 7'h23, 2'b10, 4'hF, 3, 0, 2, 3'b100, 3'b100, 6'b000110,
			0, {4{32'hFFFF98BA}}, 4'hF);
		add(mem_instr(1, 4), 32'h114, 7'h23, 2'b10, 4'hF, 2, 0, 0, 3'b100, 3'b100, 6'b000110,
			0, {4{32'h44332211}}, 4'hF);
		// Block, strided, gather, IO, sync store, control register and arithmetic
		add(mem_instr(1, 7), 32'h118, 7'h44, 2'b01, 4'hA, 0, 0, 0, 3'b100, 3'b100, 6'b000101,
			0, 128'h027FF180_D4C3B2A1_44332211_98BADCFE, 4'hA);
		add(mem_instr(1, 10), 32'h11C, 7'h44, 2'b01, 4'h6, 1, 2, 0, 3'b100, 3'b100, 6'b000101,
			0, {4{32'hD4C3B2A1}}, 4'h4);
		add(mem_instr(1, 13), 32'h144, 7'h44, 2'b01, 4'hF, 2, 1, 0, 3'b100, 3'b100, 6'b000101,
			0, {4{32'h44332211}}, 4'h2);
		add(mem_instr(1, 4), 32'h120, 7'h23, 2'b10, 4'hF, 0, 0, 0, 3'b110, 3'b000, 6'b010110,
			0, {4{IO_WORD}}, 4'hF);
		add(mem_instr(0, 5), 32'h124, 7'h23, 2'b10, 4'h1, 0, 0, 0, 3'b000, 3'b100, 6'b000110,
			0, LINE, 4'hF);
		add(mem_instr(1, 6), 32'h148, 7'h23, 2'b10, 4'h1, 0, 0, 0, 3'b000, 3'b100, 6'b000110,
			0, {4{32'hC0DE0000}}, 4'h1);
		add(32'h00001234, 32'h128, 7'h44, 2'b01, 4'h3, 0, 0, 0, 3'b000, 3'b000, 6'b000101,
			0, {4{32'hC0DE0000}}, 4'h3);
		// Rollback cases
		add(mem_instr(1, 4), 32'h12C, 7'h23, 2'b10, 4'hF, 0, 0, 0, 3'b101, 3'b100, 6'b100000,
			HANDLER, {4{32'h027FF180}}, 4'hF);
		add(mem_instr(1, 4), 32'h130, 7'h23, 2'b10, 4'hF, 0, 0, 0, 3'b100, 3'b010, 6'b101000,
			32'h12C, {4{32'h027FF180}}, 4'hF);
		add(mem_instr(1, 4), 32'h134, 7'h23, 2'b10, 4'hF, 0, 0, 0, 3'b100, 3'b000, 6'b110000,
			32'h130, {4{32'h027FF180}}, 4'hF);
		add(mem_instr(0, 4), 32'h138, 7'h23, 2'b00, 4'hF, 0, 0, 0, 3'b000, 3'b101, 6'b110000,
			32'h134, {4{32'hC0DE0000}}, 4'hF);
		add(mem_instr(1, 4), 32'h13C, 7'h5F, 2'b10, 4'hF, 3, 0, 0, 3'b100, 3'b100, 6'b100000,
			32'h98BADCFE, {4{32'h98BADCFE}}, 4'hF);
		add(32'h00000000, 32'h140, 7'h00, 2'b00, 4'h0, 0, 0, 0, 3'b000, 3'b000, 6'b000000,
			0, {4{32'hC0DE0000}}, 4'h0);

		// Random lines for scalar loads
		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			take_bits(3, r);
			op = 4'(r[2:0] % 5);
			take_bits(128, line_r);
			take_bits(4, r);
			val = model_load(line_r, r[3:2], r[1:0], op);
			e = '{mem_instr(1, op), 32'h200 + 32'(4 * n), 7'h05, 2'b10, 4'hF, r[3:2], 2'd0,
				r[1:0], 3'b100, 3'b100, line_r, 6'b000110, 32'd0, {4{val}}, 4'hF};
			tbl.push_back(e);
		end

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		check_comb(idle_e);
		check_wb(idle_e);

		// Memory-access fields of entry i travel with the cache fields of entry i-1
		for (int i = 0; i <= tbl.size() + 1; i++)
		begin
			@(negedge clk);
			if (i >= 2)
				check_wb(tbl[i - 2]);
			drive_ma(i < tbl.size() ? tbl[i] : idle_e, i >= tbl.size());
			drive_cache(i >= 1 && i <= tbl.size() ? tbl[i - 1] : idle_e,
				!(i >= 1 && i <= tbl.size()));
			#1;
			if (i >= 1 && i <= tbl.size())
				check_comb(tbl[i - 1]);
		end

		errors += i_dut.i_asserts.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end
endmodule

`default_nettype wire

// ==== wb_subsystem.f ====
verilog/wb_pkg.sv
verilog/wb_stage_if.sv
verilog/ma_result_latch.sv
verilog/load_aligner.sv
verilog/rollback_detector.sv
verilog/writeback_register.sv
verilog/wb_subsystem.sv
verification/wb_subsystem_asserts.sv
verification/wb_subsystem_tb.sv

// ==== Makefile ====
RTL = verilog/wb_pkg.sv verilog/wb_stage_if.sv verilog/ma_result_latch.sv \
	verilog/load_aligner.sv verilog/rollback_detector.sv \
	verilog/writeback_register.sv verilog/wb_subsystem.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module wb_subsystem $(RTL)

sim:
	verilator --binary --timing -f wb_subsystem.f --top-module wb_subsystem_tb \
		-o wb_subsystem_sim
	./obj_dir/wb_subsystem_sim | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
